// ==== design/pool_data_pkg.sv ====
package pool_data_pkg;

    // one matrix element, signed two's complement.
    typedef logic signed [15:0] word_t;

    // row or column count of the source matrix.
    typedef logic [9:0] dim_t;

    // edge length of the pooling window.
    typedef logic [5:0] win_t;

    // geometry of one pooling job.
    // rows must be a multiple of win_rows and cols a multiple of win_cols.
    typedef struct packed {
        dim_t rows;
        dim_t cols;
        win_t win_rows;
        win_t win_cols;
    } pool_geom_t;

    // the source is stored row-major with a row length of cols.
    // results go out row-major with no gaps between them.
    // so a job yields (rows / win_rows) * (cols / win_cols) words.

endpackage

// ==== design/pool_ctrl_pkg.sv ====
package pool_ctrl_pkg;

    // states of the pooling engine.
    typedef enum logic [1:0] {
        IDLE,  // waiting for start with done high.
        SETUP, // latches the bases and the band step.
        SCAN,  // issues the window reads, then one drain cycle.
        EMIT   // writes the window maximum.
    } pool_state_e;

    // seed for the running maximum, so any element replaces it.
    localparam pool_data_pkg::word_t WORD_MIN = 16'sh8000;

    // each window costs its reads plus one drain and one emit cycle.
    // the job adds the setup cycle and the return to idle.

endpackage

// ==== design/scratchpad_ram.sv ====
module scratchpad_ram #(
    parameter int ADDR_W = 14,
    parameter int DEPTH  = 16384
) (
    input  logic                 clk,

    input  logic                 we,
    input  logic [ADDR_W-1:0]    waddr,
    input  pool_data_pkg::word_t wdata,

    input  logic [ADDR_W-1:0]    raddr,
    output pool_data_pkg::word_t rdata
);

    pool_data_pkg::word_t mem [DEPTH];

    // both ports share one edge.
    // a read of the word being written returns the old value.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr]; // data is valid one cycle after the address.
    end

    // the host and the engine must stay inside the array.
    // the limit depends on DEPTH, which is set at the top level.
    a_waddr_in_range : assert property (
        @(posedge clk) we |-> (int'(waddr) < DEPTH)
    ) else $error("scratchpad write address %0d is beyond depth %0d", waddr, DEPTH);

    // raddr is driven every cycle.
    // so it is checked whenever it holds a known value.
    a_raddr_in_range : assert property (
        @(posedge clk) $isunknown(raddr) || (int'(raddr) < DEPTH)
    ) else $error("scratchpad read address %0d is beyond depth %0d", raddr, DEPTH);

endmodule

// ==== design/matrix_maxpool.sv ====
module matrix_maxpool #(
    parameter int ADDR_W = 14
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      start,
    output logic                      done,
    input  pool_data_pkg::pool_geom_t geom,
    input  logic [ADDR_W-1:0]         src_base,
    input  logic [ADDR_W-1:0]         dest_base,

    output logic [ADDR_W-1:0]         src_addr,
    input  pool_data_pkg::word_t      src_data,

    output logic                      res_en,
    output logic [ADDR_W-1:0]         res_addr,
    output pool_data_pkg::word_t      res_data
);

    pool_ctrl_pkg::pool_state_e state;

    logic [ADDR_W-1:0]    cur_addr;     // address issued in this cycle.
    logic [ADDR_W-1:0]    win_base;     // top-left of the current window.
    logic [ADDR_W-1:0]    band_base;    // top-left of the first window in the band.
    logic [ADDR_W-1:0]    band_step;
    logic [ADDR_W-1:0]    res_idx;
    logic [ADDR_W-1:0]    row_step;
    logic [ADDR_W-1:0]    next_win;

    pool_data_pkg::win_t  in_row;
    pool_data_pkg::win_t  in_col;
    pool_data_pkg::win_t  win_rows_m1;
    pool_data_pkg::win_t  win_cols_m1;

    pool_data_pkg::dim_t  win_col_pos;  // source column of the window's left edge.
    pool_data_pkg::dim_t  band_row_pos; // source row of the band's top edge.
    pool_data_pkg::dim_t  next_col_pos;
    pool_data_pkg::dim_t  next_row_pos;

    logic                 draining;
    logic                 rd_valid;
    logic                 last_elem;
    logic                 band_end;
    logic                 last_band;

    pool_data_pkg::word_t max_val;

    assign win_rows_m1 = geom.win_rows - pool_data_pkg::win_t'(1);
    assign win_cols_m1 = geom.win_cols - pool_data_pkg::win_t'(1);

    // at the end of a window row, jump to the left edge of the next row.
    assign row_step = ADDR_W'(geom.cols) - ADDR_W'(geom.win_cols) + ADDR_W'(1);

    assign last_elem = (in_row == win_rows_m1) && (in_col == win_cols_m1);

    assign next_col_pos = win_col_pos + pool_data_pkg::dim_t'(geom.win_cols);
    assign next_row_pos = band_row_pos + pool_data_pkg::dim_t'(geom.win_rows);
    assign band_end     = (next_col_pos == geom.cols);
    assign last_band    = (next_row_pos == geom.rows);

    // go right by one window, or down to the start of the next band.
    assign next_win = band_end ? (band_base + band_step)
                               : (win_base + ADDR_W'(geom.win_cols));

    assign src_addr = cur_addr;
    assign res_en   = (state == pool_ctrl_pkg::EMIT);
    assign res_addr = dest_base + res_idx;
    assign res_data = max_val;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= pool_ctrl_pkg::IDLE;
            done     <= 1'b1;
            draining <= 1'b0;
            in_row   <= '0;
            in_col   <= '0;
            cur_addr <= '0;
        end else begin
            case (state)
                pool_ctrl_pkg::IDLE: begin
                    if (start) begin
                        done  <= 1'b0;
                        state <= pool_ctrl_pkg::SETUP;
                    end
                end

                pool_ctrl_pkg::SETUP: begin
                    cur_addr     <= src_base;
                    win_base     <= src_base;
                    band_base    <= src_base;
                    band_step    <= ADDR_W'(geom.win_rows) * ADDR_W'(geom.cols);
                    win_col_pos  <= '0;
                    band_row_pos <= '0;
                    res_idx      <= '0;
                    in_row       <= '0;
                    in_col       <= '0;
                    draining     <= 1'b0;
                    state        <= pool_ctrl_pkg::SCAN;
                end

                pool_ctrl_pkg::SCAN: begin
                    if (draining) begin
                        draining <= 1'b0; // the last read is compared in this cycle.
                        state    <= pool_ctrl_pkg::EMIT;
                    end else if (last_elem) begin
                        in_row   <= '0;
                        in_col   <= '0;
                        draining <= 1'b1;
                    end else if (in_col == win_cols_m1) begin
                        in_col   <= '0;
                        in_row   <= in_row + pool_data_pkg::win_t'(1);
                        cur_addr <= cur_addr + row_step;
                    end else begin
                        in_col   <= in_col + pool_data_pkg::win_t'(1);
                        cur_addr <= cur_addr + ADDR_W'(1);
                    end
                end

                pool_ctrl_pkg::EMIT: begin
                    res_idx <= res_idx + ADDR_W'(1);
                    if (band_end && last_band) begin
                        done  <= 1'b1;
                        state <= pool_ctrl_pkg::IDLE;
                    end else begin
                        win_base <= next_win;
                        cur_addr <= next_win;
                        if (band_end) begin
                            band_base    <= next_win;
                            win_col_pos  <= '0;
                            band_row_pos <= next_row_pos;
                        end else begin
                            win_col_pos <= next_col_pos;
                        end
                        state <= pool_ctrl_pkg::SCAN;
                    end
                end

                default: begin
                    done  <= 1'b1;
                    state <= pool_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    // src_data belongs to the address issued one cycle earlier.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= (state == pool_ctrl_pkg::SCAN) && !draining;
        end
    end

    // the compare is signed because both operands are word_t.
    always_ff @(posedge clk) begin
        if (state == pool_ctrl_pkg::SETUP || state == pool_ctrl_pkg::EMIT) begin
            max_val <= pool_ctrl_pkg::WORD_MIN;
        end else if (rd_valid && (src_data > max_val)) begin
            max_val <= src_data;
        end
    end

    // the destination scratchpad is written only while a job runs.
    a_no_write_when_done : assert property (
        @(posedge clk) disable iff (reset) res_en |-> !done
    ) else $error("result written while done is high");

    // the host sees done drop one cycle after it pulses start.
    a_done_falls_after_start : assert property (
        @(posedge clk) disable iff (reset)
            (state == pool_ctrl_pkg::IDLE && start) |=> !done
    ) else $error("done did not fall after start in idle");

endmodule

// ==== design/pool_subsystem_top.sv ====
module pool_subsystem_top #(
    parameter int ADDR_W = 14,
    parameter int DEPTH  = 16384
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      load_en,
    input  logic [ADDR_W-1:0]         load_addr,
    input  pool_data_pkg::word_t      load_data,

    input  logic                      start,
    input  pool_data_pkg::pool_geom_t geom,
    input  logic [ADDR_W-1:0]         src_base,
    input  logic [ADDR_W-1:0]         dest_base,
    output logic                      done,

    input  logic [ADDR_W-1:0]         peek_addr,
    output pool_data_pkg::word_t      peek_data
);

    logic [ADDR_W-1:0]    src_addr;
    pool_data_pkg::word_t src_data;

    logic                 res_en;
    logic [ADDR_W-1:0]    res_addr;
    pool_data_pkg::word_t res_data;

    // the host fills this one and the engine reads it.
    scratchpad_ram #(
        .ADDR_W (ADDR_W),
        .DEPTH  (DEPTH)
    ) src_ram (
        .clk   (clk),
        .we    (load_en),
        .waddr (load_addr),
        .wdata (load_data),
        .raddr (src_addr),
        .rdata (src_data)
    );

    matrix_maxpool #(
        .ADDR_W (ADDR_W)
    ) pool_engine (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .done      (done),
        .geom      (geom),
        .src_base  (src_base),
        .dest_base (dest_base),
        .src_addr  (src_addr),
        .src_data  (src_data),
        .res_en    (res_en),
        .res_addr  (res_addr),
        .res_data  (res_data)
    );

    // the engine writes results here and the host reads them back.
    scratchpad_ram #(
        .ADDR_W (ADDR_W),
        .DEPTH  (DEPTH)
    ) dest_ram (
        .clk   (clk),
        .we    (res_en),
        .waddr (res_addr),
        .wdata (res_data),
        .raddr (peek_addr),
        .rdata (peek_data)
    );

endmodule

// ==== dv/pool_ref.svh ====
`ifndef POOL_REF_SVH
`define POOL_REF_SVH

// the largest image of any test is 8 by 8.
localparam int MAX_ELEMS = 64;

typedef pool_data_pkg::word_t image_t [MAX_ELEMS];

// one result per window.
function automatic int result_count(input pool_data_pkg::pool_geom_t g);
    return (int'(g.rows) / int'(g.win_rows)) * (int'(g.cols) / int'(g.win_cols));
endfunction

// img holds the source row-major from index 0, res gets the maxima row-major.
function automatic void pool_reference(
    input  image_t                    img,
    input  pool_data_pkg::pool_geom_t g,
    output image_t                    res
);
    int                   out_rows;
    int                   out_cols;
    int                   src_row;
    int                   src_col;
    pool_data_pkg::word_t best;

    out_rows = int'(g.rows) / int'(g.win_rows);
    out_cols = int'(g.cols) / int'(g.win_cols);
    res      = '{default: '0};
    for (int orow = 0; orow < out_rows; orow++) begin
        for (int ocol = 0; ocol < out_cols; ocol++) begin
            best = pool_data_pkg::word_t'(-32768); // any element is at least this.
            for (int r = 0; r < int'(g.win_rows); r++) begin
                for (int c = 0; c < int'(g.win_cols); c++) begin
                    src_row = orow * int'(g.win_rows) + r;
                    src_col = ocol * int'(g.win_cols) + c;
                    if (img[src_row * int'(g.cols) + src_col] > best) begin
                        best = img[src_row * int'(g.cols) + src_col];
                    end
                end
            end
            res[orow * out_cols + ocol] = best;
        end
    end
endfunction

`endif

// ==== dv/pool_tb.sv ====
module pool_tb;

    localparam int ADDR_W = 14;

    typedef logic [ADDR_W-1:0] addr_t;

    `include "pool_ref.svh"

    // each job costs 1 + N * (win_rows * win_cols + 2) + 1 cycles.
    localparam int JOB_CYCLES  = 26 + 26 + 74 + 62 + 34 + 50;
    localparam int LOAD_CYCLES = 16 + 16 + 64 + 48 + 24 + 16;
    localparam int PEEK_CYCLES = 2 * (4 + 4 + 4 + 8 + 4 + 16); // two cycles per read.
    localparam int CYCLE_LIMIT = 2 * (JOB_CYCLES + LOAD_CYCLES + PEEK_CYCLES);

    logic                      clk;
    logic                      reset;
    logic                      load_en;
    addr_t                     load_addr;
    pool_data_pkg::word_t      load_data;
    logic                      start;
    pool_data_pkg::pool_geom_t geom;
    addr_t                     src_base;
    addr_t                     dest_base;
    logic                      done;
    addr_t                     peek_addr;
    pool_data_pkg::word_t      peek_data;

    // the compare stage follows the one-cycle read latency of dest_ram.
    logic                      chk_req;
    logic                      chk_d;
    pool_data_pkg::word_t      exp_req;
    pool_data_pkg::word_t      exp_d;

    string cur_test;
    int    check_count     = 0;
    int    error_count     = 0;
    int    test_count      = 0;
    int    checks_at_start = 0;
    int    errors_at_start = 0;
    int    cycle_count     = 0;

    pool_data_pkg::word_t shadow [64]; // what the destination should hold.

    pool_subsystem_top dut (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .geom      (geom),
        .src_base  (src_base),
        .dest_base (dest_base),
        .done      (done),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        chk_d <= chk_req;
        exp_d <= exp_req;
        if (chk_d) begin
            check_value(cur_test, 32'(exp_d), 32'(peek_data));
        end
    end

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    function automatic pool_data_pkg::pool_geom_t make_geom(input int rows, input int cols,
                                                            input int win_rows,
                                                            input int win_cols);
        pool_data_pkg::pool_geom_t g;
        g.rows     = pool_data_pkg::dim_t'(rows);
        g.cols     = pool_data_pkg::dim_t'(cols);
        g.win_rows = pool_data_pkg::win_t'(win_rows);
        g.win_cols = pool_data_pkg::win_t'(win_cols);
        return g;
    endfunction

    function automatic void fill_random(output image_t img, input int n);
        img = '{default: '0};
        for (int i = 0; i < n; i++) begin
            img[i] = pool_data_pkg::word_t'($urandom);
        end
    endfunction

    task automatic begin_test(input string name);
        cur_test        = name;
        checks_at_start = check_count;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        repeat (3) @(posedge clk); // lets the last compare finish.
        test_count++;
        $display("test %s finished: %0d checks, %0d errors", cur_test,
                 check_count - checks_at_start, error_count - errors_at_start);
    endtask

    task automatic load_image(input int base, input image_t img, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= addr_t'(base + i);
            load_data <= img[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic start_job(input pool_data_pkg::pool_geom_t g, input int sb, input int db);
        @(posedge clk);
        geom      <= g;
        src_base  <= addr_t'(sb);
        dest_base <= addr_t'(db);
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(posedge clk);
        end while (done !== 1'b1);
    endtask

    task automatic peek_check(input int addr, input pool_data_pkg::word_t expected);
        @(posedge clk);
        peek_addr <= addr_t'(addr);
        exp_req   <= expected;
        chk_req   <= 1'b1;
        @(posedge clk);
        chk_req <= 1'b0;
    endtask

    task automatic read_back(input int db, input image_t expected, input int n);
        for (int i = 0; i < n; i++) begin
            peek_check(db + i, expected[i]);
            shadow[db + i] = expected[i];
        end
    endtask

    task automatic pool_job(input pool_data_pkg::pool_geom_t g, input int sb, input int db,
                            input image_t img);
        image_t expected;
        load_image(sb, img, int'(g.rows) * int'(g.cols));
        start_job(g, sb, db);
        wait_done();
        pool_reference(img, g, expected);
        read_back(db, expected, result_count(g));
    endtask

    initial begin
        image_t                    img;
        image_t                    img_b;
        image_t                    expected;
        pool_data_pkg::pool_geom_t g;
        pool_data_pkg::pool_geom_t g_b;
        int                        start_cycle;

        clk       = 1'b0;
        reset     <= 1'b1;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        start     <= 1'b0;
        geom      <= '0;
        src_base  <= '0;
        dest_base <= '0;
        peek_addr <= '0;
        chk_req   <= 1'b0;
        exp_req   <= '0;
        void'($urandom(17513));
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        begin_test("done_flow");
        @(posedge clk);
        check_value(cur_test, 1, 32'(done));
        g = make_geom(4, 4, 2, 2);
        fill_random(img, 16);
        load_image(200, img, 16);
        start_job(g, 200, 12);
        start_cycle = cycle_count; // the edge where the engine takes start.
        @(posedge clk);
        check_value(cur_test, 0, 32'(done));
        repeat (3) @(posedge clk);
        start <= 1'b1; // the engine is busy and must ignore this.
        @(posedge clk);
        start <= 1'b0;
        check_value(cur_test, 0, 32'(done));
        wait_done();
        // done is seen high again one job latency after start.
        check_value(cur_test,
                    1 + result_count(g) * (int'(g.win_rows) * int'(g.win_cols) + 2) + 1,
                    cycle_count - start_cycle);
        pool_reference(img, g, expected);
        read_back(12, expected, result_count(g));
        end_test();

        begin_test("random_4x4_win_2x2");
        fill_random(img, 16);
        pool_job(make_geom(4, 4, 2, 2), 0, 0, img);
        end_test();

        begin_test("negative_8x8_win_4x4");
        img = '{default: '0};
        for (int i = 0; i < 64; i++) begin
            img[i] = pool_data_pkg::word_t'(-1 - int'($urandom % 32767));
        end
        // the top-left window holds nothing but the most negative value.
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                img[r * 8 + c] = pool_data_pkg::word_t'(-32768);
            end
        end
        img[4 * 8 + 5] = pool_data_pkg::word_t'(-32768);
        pool_job(make_geom(8, 8, 4, 4), 0, 8, img);
        end_test();

        begin_test("win_2x4_offset");
        fill_random(img, 48);
        pool_job(make_geom(6, 8, 2, 4), 100, 4, img);
        peek_check(3, shadow[3]);   // last result of random_4x4_win_2x2.
        peek_check(10, shadow[10]); // third result of negative_8x8_win_4x4.
        end_test();

        begin_test("back_to_back");
        g   = make_geom(4, 6, 2, 3);
        g_b = make_geom(4, 4, 1, 1);
        fill_random(img, 24);
        fill_random(img_b, 16);
        load_image(300, img, 24);
        load_image(400, img_b, 16);
        start_job(g, 300, 20);
        wait_done();
        start_job(g_b, 400, 32);
        wait_done();
        pool_reference(img, g, expected);
        read_back(20, expected, result_count(g));
        pool_reference(img_b, g_b, expected);
        read_back(32, expected, result_count(g_b));
        end_test();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+dv
design/pool_data_pkg.sv
design/pool_ctrl_pkg.sv
design/scratchpad_ram.sv
design/matrix_maxpool.sv
design/pool_subsystem_top.sv
dv/pool_tb.sv

// ==== Makefile ====
TOP := pool_tb

.PHONY: run clean

# the simulator is rebuilt only when a source or the file list changes.
obj_dir/V%: all.f design/*.sv dv/*.sv dv/*.svh
	verilator --binary --timing --assert -f all.f --top-module $*

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
